/* project.f */
+incdir+source
source/breakout_pkg.sv
source/probe_sequencer.sv
source/hit_record.sv
source/bounce_control.sv
source/ball_logic.sv
verif/ball_logic_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the ball logic testbench with Verilator and run it
# the run passes only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	--top-module ball_logic_tb \
	-f project.f \
	-o ball_logic_sim \
	&& ./obj_dir/ball_logic_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* source/ball_logic.sv */
`default_nettype none

`include "breakout_settings.svh"

module ball_logic (
	input logic clk,
	input logic resetn,
	input logic logic_go,
	input breakout_pkg::coord_t x,
	input breakout_pkg::coord_t y,
	input breakout_pkg::coord_t x_max,
	input breakout_pkg::coord_t y_max,
	input breakout_pkg::coord_t size,
	input breakout_pkg::coord_t platx,
	input breakout_pkg::coord_t brickx_in,
	input breakout_pkg::coord_t bricky_in,
	input breakout_pkg::health_t health,
	output breakout_pkg::health_t game_health,
	output logic game_write,
	output breakout_pkg::coord_t memx,
	output breakout_pkg::coord_t memy,
	output logic x_du,
	output logic y_du,
	output logic update,
	output breakout_pkg::coord_t col_x [`N_AXIS],
	output breakout_pkg::coord_t col_y [`N_AXIS],
	output breakout_pkg::health_t col_health [`N_AXIS],
	output breakout_pkg::axis_t collided,
	output logic plat_collided
);

	import breakout_pkg::*;

	// sequencer to hit records
	axis_t clear;
	axis_t capture;
	coord_t cap_x;
	coord_t cap_y;
	health_t cap_health;

	// walks the probes and writes back brick health
	probe_sequencer u_seq (
		.clk(clk),
		.resetn(resetn),
		.logic_go(logic_go),
		.ballx(x),
		.bally(y),
		.x_du(x_du),
		.y_du(y_du),
		.brickx(brickx_in),
		.bricky(bricky_in),
		.brick_health(health),
		.hit(collided),
		.memx(memx),
		.memy(memy),
		.game_write(game_write),
		.game_health(game_health),
		.clear(clear),
		.capture(capture),
		.cap_x(cap_x),
		.cap_y(cap_y),
		.cap_health(cap_health),
		.update(update)
	);

	// record 0 for vertical hits, record 1 for horizontal
	for (genvar i = 0; i < `N_AXIS; i++) begin : g_axis
		hit_record u_rec (
			.clk(clk),
			.resetn(resetn),
			.clear(clear[i]),
			.capture(capture[i]),
			.cap_x(cap_x),
			.cap_y(cap_y),
			.cap_health(cap_health),
			.hit(collided[i]),
			.col_x(col_x[i]),
			.col_y(col_y[i]),
			.col_health(col_health[i])
		);
	end

	// walls, paddle and brick bounces
	bounce_control u_bounce (
		.clk(clk),
		.resetn(resetn),
		.x(x),
		.y(y),
		.x_max(x_max),
		.y_max(y_max),
		.size(size),
		.platx(platx),
		.update(update),
		.hit(collided),
		.x_du(x_du),
		.y_du(y_du),
		.plat_collided(plat_collided)
	);

endmodule

`default_nettype wire

/* source/bounce_control.sv */
`default_nettype none

`include "breakout_settings.svh"

module bounce_control (
	input logic clk,
	input logic resetn,
	input breakout_pkg::coord_t x,
	input breakout_pkg::coord_t y,
	input breakout_pkg::coord_t x_max,
	input breakout_pkg::coord_t y_max,
	input breakout_pkg::coord_t size,
	input breakout_pkg::coord_t platx,
	input logic update,
	input breakout_pkg::axis_t hit,
	output logic x_du,
	output logic y_du,
	output logic plat_collided
);

	import breakout_pkg::*;

	// right and bottom edges of the ball
	coord_t ball_xedge;
	coord_t ball_yedge;

	// right end of the paddle
	coord_t plat_xedge;

	logic on_plat_row;
	logic over_plat;

	assign ball_xedge = x + size;
	assign ball_yedge = y + size;
	assign plat_xedge = platx + coord_t'(`PLAT_W);

	// ball bottom sits exactly on the paddle top
	assign on_plat_row = (ball_yedge == coord_t'(`PLAT_Y));

	// some overlap between ball span and paddle span
	assign over_plat = (ball_xedge > platx) && (x < plat_xedge);

	assign plat_collided = on_plat_row && over_plat;

	// x direction, 1 moves right
	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_du <= 1'b0;
		end else if (x == x_max) begin
			x_du <= 1'b0;
		end else if (x == '0) begin
			x_du <= 1'b1;
		end else if (update && hit[`AXIS_H]) begin
			// side of a brick
			x_du <= ~x_du;
		end
	end

	// y direction, 1 moves down
	always_ff @(posedge clk) begin
		if (!resetn) begin
			y_du <= 1'b0;
		end else if (y == y_max) begin
			y_du <= 1'b0;
		end else if (y == '0) begin
			y_du <= 1'b1;
		end else if (plat_collided) begin
			// paddle always sends the ball back up
			y_du <= 1'b0;
		end else if (update && hit[`AXIS_V]) begin
			// top or bottom of a brick
			y_du <= ~y_du;
		end
	end

endmodule

`default_nettype wire

/* source/breakout_pkg.sv */
`default_nettype none

`include "breakout_settings.svh"

package breakout_pkg;

	// pixel position on screen
	typedef logic [`COORD_W-1:0] coord_t;

	// brick health as stored in the brick map
	typedef logic [`HEALTH_W-1:0] health_t;

	// one flag per bounce axis, bit AXIS_V and bit AXIS_H
	typedef logic [`N_AXIS-1:0] axis_t;

	// probe sequencer states
	// each probe is load address, wait, check data, write back
	typedef enum logic [3:0] {
		IDLE,
		V_LOAD,
		V_WAIT,
		V_CHECK,
		V_WRITE,
		H_LOAD,
		H_WAIT,
		H_CHECK,
		H_WRITE,
		D_LOAD,
		D_WAIT,
		D_CHECK,
		D_WRITE,
		UPDATE
	} probe_state_t;

endpackage

`default_nettype wire

/* source/breakout_settings.svh */
`ifndef BREAKOUT_SETTINGS_SVH
`define BREAKOUT_SETTINGS_SVH

// screen coordinate width, 640x480 fits in 10 bits
`define COORD_W 10

// brick health, zero means the cell is empty
`define HEALTH_W 2

// top edge of the paddle, in screen rows
`define PLAT_Y 440

// paddle width in pixels
`define PLAT_W 64

// one hit record per bounce axis
`define N_AXIS 2

// vertical probe hit, flips y
`define AXIS_V 0

// horizontal probe hit, flips x
`define AXIS_H 1

`endif

/* source/hit_record.sv */
`default_nettype none

module hit_record (
	input logic clk,
	input logic resetn,
	input logic clear,
	input logic capture,
	input breakout_pkg::coord_t cap_x,
	input breakout_pkg::coord_t cap_y,
	input breakout_pkg::health_t cap_health,
	output logic hit,
	output breakout_pkg::coord_t col_x,
	output breakout_pkg::coord_t col_y,
	output breakout_pkg::health_t col_health
);

	// hit flag for this axis
	// capture wins, though the sequencer never
	// raises both in one cycle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			hit <= 1'b0;
		end else if (capture) begin
			hit <= 1'b1;
		end else if (clear) begin
			hit <= 1'b0;
		end
	end

	// brick that was hit and its health after the hit
	// kept past clear, only the next capture replaces it
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_x <= '0;
			col_y <= '0;
			col_health <= '0;
		end else if (capture) begin
			col_x <= cap_x;
			col_y <= cap_y;
			col_health <= cap_health;
		end
	end

endmodule

`default_nettype wire

/* source/probe_sequencer.sv */
`default_nettype none

`include "breakout_settings.svh"

module probe_sequencer (
	input logic clk,
	input logic resetn,
	input logic logic_go,
	input breakout_pkg::coord_t ballx,
	input breakout_pkg::coord_t bally,
	input logic x_du,
	input logic y_du,
	input breakout_pkg::coord_t brickx,
	input breakout_pkg::coord_t bricky,
	input breakout_pkg::health_t brick_health,
	input breakout_pkg::axis_t hit,
	output breakout_pkg::coord_t memx,
	output breakout_pkg::coord_t memy,
	output logic game_write,
	output breakout_pkg::health_t game_health,
	output breakout_pkg::axis_t clear,
	output breakout_pkg::axis_t capture,
	output breakout_pkg::coord_t cap_x,
	output breakout_pkg::coord_t cap_y,
	output breakout_pkg::health_t cap_health,
	output logic update
);

	import breakout_pkg::*;

	probe_state_t state;
	probe_state_t state_next;

	// ball position one step ahead
	coord_t x_new;
	coord_t y_new;

	logic start;
	logic is_check;
	logic brick_found;
	health_t dec_health;

	// go is only looked at while idle
	assign start = (state == IDLE) && logic_go;

	assign is_check = (state == V_CHECK) || (state == H_CHECK) || (state == D_CHECK);

	// empty cells read back as zero health
	assign brick_found = (brick_health != '0);
	assign dec_health = brick_health - health_t'(1);

	// both records drop their flag at the start of a step
	assign clear = {`N_AXIS{start}};

	// hit payload goes straight from the memory read data
	assign cap_x = brickx;
	assign cap_y = bricky;
	assign cap_health = dec_health;

	assign update = (state == UPDATE);

	always_comb begin
		capture = '0;
		if (brick_found) begin
			case (state)
				V_CHECK: capture[`AXIS_V] = 1'b1;
				H_CHECK: capture[`AXIS_H] = 1'b1;
				// corner hit bounces on both axes
				D_CHECK: capture = '1;
				default: capture = '0;
			endcase
		end
	end

	always_comb begin
		case (state)
			IDLE: state_next = logic_go ? V_LOAD : IDLE;
			V_LOAD: state_next = V_WAIT;
			V_WAIT: state_next = V_CHECK;
			V_CHECK: state_next = V_WRITE;
			V_WRITE: state_next = H_LOAD;
			H_LOAD: state_next = H_WAIT;
			H_WAIT: state_next = H_CHECK;
			H_CHECK: state_next = H_WRITE;
			// diagonal only matters when both sides were clear
			H_WRITE: state_next = (hit != '0) ? UPDATE : D_LOAD;
			D_LOAD: state_next = D_WAIT;
			D_WAIT: state_next = D_CHECK;
			D_CHECK: state_next = D_WRITE;
			D_WRITE: state_next = UPDATE;
			UPDATE: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// next position, one pixel along each direction
	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_new <= '0;
			y_new <= '0;
		end else if (start) begin
			x_new <= x_du ? ballx + coord_t'(1) : ballx - coord_t'(1);
			y_new <= y_du ? bally + coord_t'(1) : bally - coord_t'(1);
		end
	end

	// probe address, held through wait, check and write
	always_ff @(posedge clk) begin
		if (!resetn) begin
			memx <= '0;
			memy <= '0;
		end else begin
			case (state)
				// straight above or below
				V_LOAD: begin
					memx <= ballx;
					memy <= y_new;
				end
				// straight left or right
				H_LOAD: begin
					memx <= x_new;
					memy <= bally;
				end
				// the corner ahead
				D_LOAD: begin
					memx <= x_new;
					memy <= y_new;
				end
				default: begin
					memx <= memx;
					memy <= memy;
				end
			endcase
		end
	end

	// write-back, high for the whole write state after a hit
	always_ff @(posedge clk) begin
		if (!resetn) begin
			game_write <= 1'b0;
			game_health <= '0;
		end else begin
			game_write <= is_check && brick_found;
			if (is_check && brick_found) begin
				game_health <= dec_health;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/ball_logic_tb.sv */
`default_nettype none

`include "breakout_settings.svh"

module ball_logic_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import breakout_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int N_STEPS = 400;
	localparam int STEP_CYCLES = 20;

	logic clk;
	logic resetn;
	logic logic_go;
	coord_t x;
	coord_t y;
	coord_t x_max;
	coord_t y_max;
	coord_t size;
	coord_t platx;
	coord_t brickx_in;
	coord_t bricky_in;
	health_t health;
	health_t game_health;
	logic game_write;
	coord_t memx;
	coord_t memy;
	logic x_du;
	logic y_du;
	logic update;
	coord_t col_x [`N_AXIS];
	coord_t col_y [`N_AXIS];
	health_t col_health [`N_AXIS];
	axis_t collided;
	logic plat_collided;

	// one brick cell per 16x16 pixels
	// indices wrap at 32 cells
	health_t brick_map [32][32];
	health_t pred_map [32][32];

	// reference state
	logic model_x_du;
	logic model_y_du;
	coord_t exp_col_x [`N_AXIS];
	coord_t exp_col_y [`N_AXIS];
	health_t exp_col_health [`N_AXIS];
	axis_t exp_hit;
	int exp_upd_k;
	// expected write per cycle after the go edge
	logic exp_wr [1:STEP_CYCLES];
	coord_t exp_wx [1:STEP_CYCLES];
	coord_t exp_wy [1:STEP_CYCLES];
	health_t exp_wh [1:STEP_CYCLES];
	int unsigned seed_val;

	ball_logic DUT (
		.clk(clk),
		.resetn(resetn),
		.logic_go(logic_go),
		.x(x),
		.y(y),
		.x_max(x_max),
		.y_max(y_max),
		.size(size),
		.platx(platx),
		.brickx_in(brickx_in),
		.bricky_in(bricky_in),
		.health(health),
		.game_health(game_health),
		.game_write(game_write),
		.memx(memx),
		.memy(memy),
		.x_du(x_du),
		.y_du(y_du),
		.update(update),
		.col_x(col_x),
		.col_y(col_y),
		.col_health(col_health),
		.collided(collided),
		.plat_collided(plat_collided)
	);

	// memory answers in the same cycle
	// brick corner is the cell origin
	assign brickx_in = memx & ~coord_t'(15);
	assign bricky_in = memy & ~coord_t'(15);
	assign health = brick_map[memy[8:4]][memx[8:4]];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// every step fits in STEP_CYCLES clocks
	initial begin
		#((N_STEPS + 10) * STEP_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all frame steps were done");
		stop_run();
	end

	task automatic stop_run();
		$display(">>> FAIL");
		$fatal(1, "run stopped on error");
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic report_text(input string what);
		$display("ERROR time=%0t %s", $time, what);
		stop_run();
	endtask

	task automatic fill_map();
		for (int iy = 0; iy < 32; iy++) begin
			for (int ix = 0; ix < 32; ix++) begin
				// roughly three cells in eight hold a brick
				brick_map[iy][ix] = (($urandom % 2) == 0) ? health_t'($urandom % 4) : '0;
			end
		end
	endtask

	// paddle contact by the game rule
	function automatic logic paddle_rule();
		coord_t bottom;
		coord_t right;
		coord_t pad_end;
		bottom = y + size;
		right = x + size;
		pad_end = platx + coord_t'(`PLAT_W);
		return (bottom == coord_t'(`PLAT_Y)) && (right > platx) && (x < pad_end);
	endfunction

	// one probe of the reference map
	// k is the cycle of its write
	task automatic predict_probe(input coord_t px, input coord_t py, input int k,
		input axis_t rec);
		health_t h;
		h = pred_map[py[8:4]][px[8:4]];
		if (h != '0) begin
			exp_wr[k] = 1'b1;
			exp_wx[k] = px;
			exp_wy[k] = py;
			exp_wh[k] = h - health_t'(1);
			// later probes see the decremented brick
			pred_map[py[8:4]][px[8:4]] = exp_wh[k];
			for (int i = 0; i < `N_AXIS; i++) begin
				if (rec[i]) begin
					exp_col_x[i] = px & ~coord_t'(15);
					exp_col_y[i] = py & ~coord_t'(15);
					exp_col_health[i] = exp_wh[k];
				end
			end
			exp_hit = exp_hit | rec;
		end
	endtask

	task automatic predict_step();
		coord_t xn;
		coord_t yn;
		xn = model_x_du ? x + coord_t'(1) : x - coord_t'(1);
		yn = model_y_du ? y + coord_t'(1) : y - coord_t'(1);
		for (int k = 1; k <= STEP_CYCLES; k++) begin
			exp_wr[k] = 1'b0;
		end
		pred_map = brick_map;
		exp_hit = '0;
		predict_probe(x, yn, 4, axis_t'(1 << `AXIS_V));
		predict_probe(xn, y, 8, axis_t'(1 << `AXIS_H));
		// corner probe only when both sides missed
		if (exp_hit == '0) begin
			predict_probe(xn, yn, 12, '1);
			exp_upd_k = 13;
		end else begin
			exp_upd_k = 9;
		end
	endtask

	// called at the falling edge
	// returns 1 ns past the next rising edge
	task automatic advance(input logic upd_now, input axis_t hits);
		logic nx;
		logic ny;
		logic on_plat;
		on_plat = paddle_rule();
		assert (plat_collided === on_plat)
			else report_value("plat_collided", 32'(plat_collided), 32'(on_plat));
		assert (x_du === model_x_du) else report_value("x_du", 32'(x_du), 32'(model_x_du));
		assert (y_du === model_y_du) else report_value("y_du", 32'(y_du), 32'(model_y_du));
		nx = model_x_du;
		if (x == x_max) nx = 1'b0;
		else if (x == '0) nx = 1'b1;
		else if (upd_now && hits[`AXIS_H]) nx = ~model_x_du;
		ny = model_y_du;
		if (y == y_max) ny = 1'b0;
		else if (y == '0) ny = 1'b1;
		else if (on_plat) ny = 1'b0;
		else if (upd_now && hits[`AXIS_V]) ny = ~model_y_du;
		@(posedge clk);
		model_x_du = nx;
		model_y_du = ny;
		#1;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		assert (game_write === 1'b0) else report_value("game_write", 32'(game_write), 0);
		assert (update === 1'b0) else report_value("update", 32'(update), 0);
		advance(1'b0, '0);
	endtask

	// random position and limits
	// some steps put the ball on a wall or on the paddle row
	task automatic pick_position();
		x_max = coord_t'(200 + $urandom % 300);
		y_max = coord_t'(200 + $urandom % 250);
		size = coord_t'(4 + $urandom % 12);
		platx = coord_t'($urandom % 400);
		x = coord_t'($urandom % (int'(x_max) + 1));
		y = coord_t'($urandom % (int'(y_max) + 1));
		case ($urandom % 8)
			0: x = x_max;
			1: x = '0;
			2: y = y_max;
			3: y = '0;
			4: begin
				y = coord_t'(`PLAT_Y) - size;
				x = platx + coord_t'($urandom % `PLAT_W);
			end
			default: ;
		endcase
	endtask

	task automatic run_step();
		int k;
		logic seen;
		health_t map_dec;
		pick_position();
		predict_step();
		logic_go = 1'b1;
		idle_cycle();
		logic_go = 1'b0;
		k = 1;
		seen = 1'b0;
		// wait for update within the step length
		while (!seen && k <= STEP_CYCLES) begin
			@(negedge clk);
			assert (game_write === exp_wr[k])
				else report_value("game_write", 32'(game_write), 32'(exp_wr[k]));
			if (exp_wr[k]) begin
				assert (memx === exp_wx[k]) else report_value("memx", 32'(memx), 32'(exp_wx[k]));
				assert (memy === exp_wy[k]) else report_value("memy", 32'(memy), 32'(exp_wy[k]));
				map_dec = brick_map[memy[8:4]][memx[8:4]] - health_t'(1);
				assert (game_health === map_dec)
					else report_value("game_health", 32'(game_health), 32'(map_dec));
			end
			if (update === 1'b1) begin
				seen = 1'b1;
				assert (k == exp_upd_k) else report_value("update cycle", k, exp_upd_k);
				assert (collided === exp_hit)
					else report_value("collided", 32'(collided), 32'(exp_hit));
				for (int i = 0; i < `N_AXIS; i++) begin
					assert (col_x[i] === exp_col_x[i])
						else report_value("col_x", 32'(col_x[i]), 32'(exp_col_x[i]));
					assert (col_y[i] === exp_col_y[i])
						else report_value("col_y", 32'(col_y[i]), 32'(exp_col_y[i]));
					assert (col_health[i] === exp_col_health[i])
						else report_value("col_health", 32'(col_health[i]),
							32'(exp_col_health[i]));
				end
			end
			advance(k == exp_upd_k, exp_hit);
			// write lands in the map once its cycle is over
			if (exp_wr[k]) begin
				brick_map[exp_wy[k][8:4]][exp_wx[k][8:4]] = exp_wh[k];
			end
			k++;
		end
		if (!seen) report_text("update pulse did not arrive within the frame step");
	endtask

	initial begin
		seed_val = $urandom(73192);
		resetn = 1'b0;
		logic_go = 1'b0;
		x = coord_t'(100);
		y = coord_t'(100);
		x_max = coord_t'(300);
		y_max = coord_t'(300);
		size = coord_t'(8);
		platx = coord_t'(200);
		model_x_du = 1'b0;
		model_y_du = 1'b0;
		for (int i = 0; i < `N_AXIS; i++) begin
			exp_col_x[i] = '0;
			exp_col_y[i] = '0;
			exp_col_health[i] = '0;
		end
		fill_map();
		repeat (5) @(posedge clk);
		#1;
		resetn = 1'b1;
		@(negedge clk);
		assert (update === 1'b0) else report_value("update", 32'(update), 0);
		assert (game_write === 1'b0) else report_value("game_write", 32'(game_write), 0);
		assert (collided === '0) else report_value("collided", 32'(collided), 0);
		advance(1'b0, '0);
		for (int s = 0; s < N_STEPS; s++) begin
			// hits wear the map down so it is refilled now and then
			if ((s % 50) == 49) fill_map();
			run_step();
			repeat ($urandom % 3) idle_cycle();
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
